/* hdl/bit_image_ram.sv */
// left and right bit-pixel row memories
// one external write port, shared registered read address for both images
`default_nettype none

module bit_image_ram
    import bm_geom_pkg::*, bm_proto_pkg::*;
(
    input  wire            clk,
    input  wire            reset,
    input  wire            wr_en,
    input  wire bm_wr_t    wr,
    input  wire row_addr_t rd_addr,
    output img_row_t       left_row,
    output img_row_t       right_row
);

    img_row_t left_mem  [img_h];   // one word per image row
    img_row_t right_mem [img_h];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (wr.sel)                            // steer by image select
                img_left:  left_mem[wr.addr]  <= wr.data;
                img_right: right_mem[wr.addr] <= wr.data;
                default:   ;
            endcase
        end
    end

    // both images read at the same row, one cycle latency
    always_ff @(posedge clk) begin
        left_row  <= left_mem[rd_addr];
        right_row <= right_mem[rd_addr];
    end

    // the read address only moves while block_fetch walks a block,
    // so a write then would change an image under a running frame
    a_no_wr_during_read: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> $stable(rd_addr)
    );

endmodule

`default_nettype wire

/* hdl/block_fetch.sv */
// reads the four rows of a block from both images
// slices left block bits and right search strip, holds result until taken
`default_nettype none

module block_fetch
    import bm_geom_pkg::*, bm_proto_pkg::*;
#(
    parameter int num_disp = 8
) (
    input  wire           clk,
    input  wire           reset,
    input  wire           job_valid,
    output logic          job_ready,
    input  wire bm_job_t  job,
    output row_addr_t     rd_addr,
    input  wire img_row_t left_row,
    input  wire img_row_t right_row,
    output logic          fet_valid,
    input  wire           fet_ready,
    output bm_fetched_t   fet
);

    localparam int strip_used = blk_w + num_disp - 1;   // right bits actually searched
    localparam logic [strip_w-1:0] strip_mask = {strip_w{1'b1}} >> (strip_w - strip_used);

    logic                       busy;
    logic [$clog2(blk_h+1)-1:0] phase;   // step k reads row k, captures row k-1
    bm_job_t                    job_q;   // block being read
    logic                       job_fire;

    assign job_ready = !busy && !fet_valid;              // only with the output slot free
    assign job_fire  = job_valid && job_ready;
    assign rd_addr   = row_addr_t'(job_q.row * blk_h + phase);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            phase     <= '0;
            fet_valid <= 1'b0;
            job_q     <= '0;
        end else begin
            if (job_fire) begin
                busy  <= 1'b1;
                job_q <= job;
            end else if (busy) begin
                if (phase == blk_h) begin            // last row captured this cycle
                    busy      <= 1'b0;
                    phase     <= '0;
                    fet_valid <= 1'b1;
                end else begin
                    phase <= phase + 1'b1;
                end
            end
            if (fet_valid && fet_ready) fet_valid <= 1'b0;
        end
    end

    // row data is one cycle behind its address
    always_ff @(posedge clk) begin
        if (job_fire) fet.job <= job;
        if (busy && phase != '0) begin
            fet.ref_blk[(phase-1)*blk_w +: blk_w] <= left_row[job_q.col*blk_w +: blk_w];
            fet.strip[(phase-1)*strip_w +: strip_w] <=
                right_row[job_q.col*blk_w +: strip_w] & strip_mask;  // zero unused offsets
        end
    end

endmodule

`default_nettype wire

/* hdl/block_match_ctrl.sv */
// frame walk FSM issuing block jobs in row-major order
// credit counter gating issue, outstanding result count, idle status
`default_nettype none

module block_match_ctrl
    import bm_geom_pkg::*, bm_proto_pkg::*;
#(
    parameter int num_credits = 2
) (
    input  wire     clk,
    input  wire     reset,
    input  wire     start,
    output logic    idle,
    output logic    job_valid,
    input  wire     job_ready,
    output bm_job_t job,
    input  wire     res_valid,
    input  wire     credit_return
);

    localparam int cred_w = $clog2(num_credits + 1);

    ctrl_state_e       state;
    logic [cred_w-1:0] credits;       // free result slots downstream
    logic [cred_w-1:0] outstanding;   // jobs issued, result not yet seen
    logic              job_fire;
    logic              last_blk;

    assign idle      = (state == st_idle);
    assign job_valid = (state == st_issue) && (credits != '0);  // no credit, no job
    assign job_fire  = job_valid && job_ready;
    assign last_blk  = (job.row == blk_row_t'(block_rows - 1)) &&
                       (job.col == blk_col_t'(blocks_per_row - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            job   <= '0;
        end else begin
            case (state)
                st_idle: if (start) begin
                    state <= st_issue;
                    job   <= '0;                      // frame starts at block 0,0
                end
                st_issue: if (job_fire) begin
                    if (last_blk) begin
                        state <= st_drain;
                    end else if (job.col == blk_col_t'(blocks_per_row - 1)) begin
                        job.col <= '0;                // wrap to next block row
                        job.row <= job.row + 1'b1;
                    end else begin
                        job.col <= job.col + 1'b1;
                    end
                end
                st_drain: if (res_valid && outstanding == cred_w'(1)) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credits     <= cred_w'(num_credits);      // full pool after reset
            outstanding <= '0;
        end else begin
            case ({job_fire, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;                            // both or neither, no change
            endcase
            case ({job_fire, res_valid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: ;
            endcase
        end
    end

    // a credit coming back with the pool full would overflow it
    a_credit_bound: assert property (
        @(posedge clk) disable iff (reset)
        credit_return |-> (credits < cred_w'(num_credits)) || job_fire
    );

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (reset)
        start |-> state == st_idle
    );

endmodule

`default_nettype wire

/* hdl/bm_geom_pkg.sv */
// image and block geometry for the stereo block matcher
// row, block, strip, cost and disparity types sized from it
`default_nettype none

package bm_geom_pkg;

    localparam int img_w          = 32;                        // bits per image row
    localparam int img_h          = 8;                         // rows per image
    localparam int blk_w          = 4;
    localparam int blk_h          = 4;
    localparam int max_disp       = 8;                         // widest search the types hold
    localparam int blocks_per_row = (img_w - max_disp) / blk_w; // 6
    localparam int block_rows     = img_h / blk_h;             // 2
    localparam int strip_w        = blk_w + max_disp - 1;      // right bits per strip row

    typedef logic [img_w-1:0]                     img_row_t;
    typedef logic [$clog2(img_h)-1:0]             row_addr_t;
    typedef logic [$clog2(blocks_per_row)-1:0]    blk_col_t;
    typedef logic [$clog2(block_rows)-1:0]        blk_row_t;
    typedef logic [blk_h*blk_w-1:0]               ref_block_t;  // row r at [r*blk_w +: blk_w]
    typedef logic [blk_h*strip_w-1:0]             strip_t;      // row r at [r*strip_w +: strip_w]
    typedef logic [$clog2(blk_h*blk_w+1)-1:0]     cost_t;       // 0..16
    typedef logic [$clog2(max_disp)-1:0]          disp_t;

endpackage

`default_nettype wire

/* hdl/bm_proto_pkg.sv */
// transfer structs between matcher stages: write, job, fetched block, result
// plus controller state and image select encodings
`default_nettype none

package bm_proto_pkg;

    import bm_geom_pkg::*;

    typedef enum logic {
        img_left  = 1'b0,
        img_right = 1'b1
    } img_sel_e;

    typedef struct packed {
        img_sel_e  sel;      // target image
        row_addr_t addr;
        img_row_t  data;
    } bm_wr_t;              // 36 bits

    typedef struct packed {
        blk_row_t row;
        blk_col_t col;
    } bm_job_t;             // 4 bits

    typedef struct packed {
        bm_job_t    job;
        ref_block_t ref_blk;  // left block bits
        strip_t     strip;    // right search window
    } bm_fetched_t;         // 64 bits

    typedef struct packed {
        blk_row_t row;
        blk_col_t col;
        disp_t    disp;
        cost_t    cost;
    } bm_result_t;          // 12 bits

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_drain
    } ctrl_state_e;

endpackage

`default_nettype wire

/* hdl/disparity_search.sv */
// Hamming scoring of one block against each disparity offset
// running minimum with ties to the smaller offset, one result per block
`default_nettype none

module disparity_search
    import bm_geom_pkg::*, bm_proto_pkg::*;
#(
    parameter int num_disp = 8
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              fet_valid,
    output logic             fet_ready,
    input  wire bm_fetched_t fet,
    output logic             res_valid,
    output bm_result_t       res
);

    localparam int dcnt_w = $clog2(num_disp + 1);

    logic              busy;
    logic [dcnt_w-1:0] d_cnt;      // current offset, num_disp means emit
    bm_fetched_t       blk_q;      // latched block and strip
    ref_block_t        diff_bits;
    cost_t             cost;
    cost_t             best_cost;
    disp_t             best_disp;
    logic              scoring;

    assign fet_ready = !busy;
    assign scoring   = busy && (d_cnt != dcnt_w'(num_disp));

    // strip row shifted right by d lines up with the reference row
    always_comb begin
        diff_bits = '0;
        if (scoring) begin
            for (int r = 0; r < blk_h; r++) begin
                diff_bits[r*blk_w +: blk_w] = blk_q.ref_blk[r*blk_w +: blk_w] ^
                                              blk_q.strip[r*strip_w + d_cnt +: blk_w];
            end
        end
        cost = cost_t'($countones(diff_bits));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            d_cnt     <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;                      // single cycle pulse
            if (fet_valid && fet_ready) begin
                busy  <= 1'b1;
                d_cnt <= '0;
            end else if (scoring) begin
                d_cnt <= d_cnt + 1'b1;
            end else if (busy) begin
                busy      <= 1'b0;                  // extra cycle, result out
                res_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fet_valid && fet_ready) begin
            blk_q     <= fet;
            best_cost <= '1;                        // above any real cost
            best_disp <= '0;
        end else if (scoring && cost < best_cost) begin  // strict, earlier d keeps ties
            best_cost <= cost;
            best_disp <= disp_t'(d_cnt);
        end
        if (busy && !scoring) begin
            res <= '{row: blk_q.job.row, col: blk_q.job.col,
                     disp: best_disp, cost: best_cost};
        end
    end

    a_cost_range: assert property (
        @(posedge clk) disable iff (reset)
        res_valid |-> res.cost <= cost_t'(blk_w * blk_h)
    );

endmodule

`default_nettype wire

/* hdl/stereo_bm_top.sv */
// stereo block matcher top level
// row memory, frame controller, block fetch and disparity search
`default_nettype none

module stereo_bm_top
    import bm_geom_pkg::*, bm_proto_pkg::*;
#(
    parameter int num_disp    = 8,
    parameter int num_credits = 2
) (
    input  wire         clk,
    input  wire         reset,
    input  wire         wr_en,
    input  wire bm_wr_t wr,
    input  wire         start,
    output logic        idle,
    output logic        res_valid,
    output bm_result_t  res,
    input  wire         credit_return
);

    logic        job_valid;
    logic        job_ready;
    bm_job_t     job;
    row_addr_t   rd_addr;
    img_row_t    left_row;
    img_row_t    right_row;
    logic        fet_valid;
    logic        fet_ready;
    bm_fetched_t fet;

    bit_image_ram u_ram (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr        (wr),
        .rd_addr   (rd_addr),
        .left_row  (left_row),
        .right_row (right_row)
    );

    block_match_ctrl #(
        .num_credits (num_credits)
    ) u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .idle          (idle),
        .job_valid     (job_valid),
        .job_ready     (job_ready),
        .job           (job),
        .res_valid     (res_valid),      // result stream also closes out the frame
        .credit_return (credit_return)
    );

    block_fetch #(
        .num_disp (num_disp)
    ) u_fetch (
        .clk       (clk),
        .reset     (reset),
        .job_valid (job_valid),
        .job_ready (job_ready),
        .job       (job),
        .rd_addr   (rd_addr),
        .left_row  (left_row),
        .right_row (right_row),
        .fet_valid (fet_valid),
        .fet_ready (fet_ready),
        .fet       (fet)
    );

    disparity_search #(
        .num_disp (num_disp)
    ) u_search (
        .clk       (clk),
        .reset     (reset),
        .fet_valid (fet_valid),
        .fet_ready (fet_ready),
        .fet       (fet),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the stereo block matcher testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module stereo_bm_tb -o stereo_bm_sim

out=$(./obj_dir/stereo_bm_sim)
echo "$out"

if grep -qx "=== PASS ===" <<< "$out"; then
    exit 0
fi
exit 1

/* verif/stereo_bm_cases.txt */
# per frame: 8 lines "left_row right_row" in hex, bit c is column c, rows 0 to 7
# then 12 lines "disp cost" in decimal, blocks in row-major order
# frame 1: right is left shifted up 3 columns on rows 0-3 and 1 column on rows 4-7
11111111 88888888
0f0f3c3c 7879e1e0
12345678 91a2b3c0
0a5a5a5a 52d2d2d0
11111111 22222222
6b3e2c97 d67c592e
40c0ffee 8181ffdc
00f00f00 01e01e00
3 0
3 0
3 0
3 0
3 0
3 0
1 0
1 0
1 0
1 0
1 0
1 0
# frame 2: left clear on rows 0-3, set on rows 4-7, one right row everywhere
# many offsets share the lowest cost here
00000000 342f89e3
00000000 342f89e3
00000000 342f89e3
00000000 342f89e3
ffffffff 342f89e3
ffffffff 342f89e3
ffffffff 342f89e3
ffffffff 342f89e3
1 4
5 4
1 4
0 4
6 0
2 0
5 0
1 0
7 0
3 0
0 0
6 4

/* verif/stereo_bm_tb.sv */
// testbench for the stereo block matcher
// file-driven images and expected results, random credit return, checks, watchdog
`default_nettype none

module stereo_bm_tb
    import bm_geom_pkg::*, bm_proto_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_disp       = 8;
    localparam int num_credits    = 2;
    localparam int clk_period     = 10;
    localparam int n_frames       = 2;
    localparam int n_blocks       = blocks_per_row * block_rows;  // 12 per frame
    localparam int timeout_cycles = n_frames * n_blocks * (num_disp + 8) * 20 + 1000;

    logic       clk;
    logic       reset;
    logic       wr_en;
    bm_wr_t     wr;
    logic       start;
    logic       idle;
    logic       res_valid;
    bm_result_t res;
    logic       credit_return = 1'b0;

    logic [15:0] lfsr_state = 16'd20579;  // credit return coin
    bm_result_t  exp_q[$];                // expected results in arrival order
    int          fd;
    int          frame_no;
    int          blk_no;
    int          received;                // results seen
    int          returned;                // credits handed back
    int          checked;
    int          mismatch_count;
    int          fail_count;
    logic        idle_check_due = 1'b0;
    logic        frame_done     = 1'b0;

    stereo_bm_top #(
        .num_disp    (num_disp),
        .num_credits (num_credits)
    ) i_dut (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .wr            (wr),
        .start         (start),
        .idle          (idle),
        .res_valid     (res_valid),
        .res           (res),
        .credit_return (credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // 16 bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic check_result(input string name, input bm_result_t expected,
                                input bm_result_t actual);
        checked++;
        if (actual !== expected) begin
            $write("MISMATCH %s: expected row %0d col %0d disp %0d cost %0d,",
                   name, expected.row, expected.col, expected.disp, expected.cost);
            $display(" actual row %0d col %0d disp %0d cost %0d",
                     actual.row, actual.col, actual.disp, actual.cost);
            mismatch_count++;
        end
    endtask

    task automatic check_idle(input string name, input logic expected, input logic actual);
        checked++;
        if (actual !== expected) begin
            $display("MISMATCH %s: expected idle %b, actual idle %b", name, expected, actual);
            mismatch_count++;
        end
    endtask

    // next line that is neither blank nor a # comment (empty at end of file)
    task automatic next_data_line(output string line);
        string s;
        int    n;
        line = "";
        while (!$feof(fd)) begin
            n = $fgets(s, fd);
            if (n > 1 && s[0] != "#") begin
                line = s;
                return;
            end
        end
    endtask

    task automatic write_row(input img_sel_e sel, input row_addr_t addr, input img_row_t data);
        @(posedge clk);
        wr_en <= 1'b1;
        wr    <= '{sel: sel, addr: addr, data: data};
    endtask

    // both images of one frame then its 12 expected results
    task automatic load_frame();
        string      line;
        img_row_t   left_val;
        img_row_t   right_val;
        int         d_val;
        int         c_val;
        bm_result_t exp_res;
        for (int r = 0; r < img_h; r++) begin
            next_data_line(line);
            if ($sscanf(line, "%h %h", left_val, right_val) != 2) begin
                $display("cases file: image row %0d of frame %0d missing or malformed",
                         r, frame_no);
                fail_count++;
            end
            write_row(img_left, row_addr_t'(r), left_val);
            write_row(img_right, row_addr_t'(r), right_val);
        end
        for (int b = 0; b < n_blocks; b++) begin
            next_data_line(line);
            if ($sscanf(line, "%d %d", d_val, c_val) != 2) begin
                $display("cases file: result %0d of frame %0d missing or malformed",
                         b, frame_no);
                fail_count++;
            end
            exp_res.row  = blk_row_t'(b / blocks_per_row);  // row-major block order
            exp_res.col  = blk_col_t'(b % blocks_per_row);
            exp_res.disp = disp_t'(d_val);
            exp_res.cost = cost_t'(c_val);
            exp_q.push_back(exp_res);
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        wr_en <= 1'b0;       // last row already written
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // consumer hands back a credit at random for results it holds
    always @(posedge clk) begin
        if (reset) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= (received > returned) && lfsr_state[0];
            lfsr_state    <= galois_step(lfsr_state);  // one step per bit taken
        end
    end

    // result monitor sampled mid-cycle
    always @(negedge clk) begin
        bm_result_t exp_res;
        if (!reset) begin
            if (idle_check_due) begin
                check_idle($sformatf("frame%0d_idle_after_last", frame_no), 1'b1, idle);
                idle_check_due = 1'b0;
                frame_done     = 1'b1;
            end
            if (credit_return) returned++;
            if (res_valid) begin
                received++;
                if (exp_q.size() == 0) begin
                    $display("result for block row %0d col %0d arrived when none was expected",
                             res.row, res.col);
                    fail_count++;
                end else begin
                    exp_res = exp_q.pop_front();
                    check_result($sformatf("frame%0d_block%0d", frame_no, blk_no), exp_res, res);
                    blk_no++;
                    if (exp_q.size() == 0) idle_check_due = 1'b1;  // last of the frame
                end
            end
            if (received - returned > num_credits) begin
                $display("%0d results held without credit, more than the %0d credits",
                         received - returned, num_credits);
                fail_count++;
            end
        end
    end

    initial begin
        #(timeout_cycles * clk_period);
        $display("watchdog: run did not finish within %0d cycles", timeout_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        reset = 1'b1;
        wr_en = 1'b0;
        wr    = '0;
        start = 1'b0;
        fd    = $fopen("verif/stereo_bm_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/stereo_bm_cases.txt");
            fail_count++;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_idle("idle_after_reset", 1'b1, idle);
        if (res_valid !== 1'b0) begin
            $display("res_valid is not low after reset");
            fail_count++;
        end
        if (fd != 0) begin
            for (int f = 0; f < n_frames; f++) begin
                frame_no   = f + 1;
                blk_no     = 0;
                frame_done = 1'b0;
                load_frame();     // rewrites both images while idle
                pulse_start();
                wait (frame_done);
            end
            $fclose(fd);
        end
        repeat (20) @(posedge clk);  // room for a duplicate result to show up
        $display("summary: %0d checks, %0d mismatches, %0d other errors",
                 checked, mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hdl/bm_geom_pkg.sv
hdl/bm_proto_pkg.sv
hdl/bit_image_ram.sv
hdl/block_match_ctrl.sv
hdl/block_fetch.sv
hdl/disparity_search.sv
hdl/stereo_bm_top.sv
verif/stereo_bm_tb.sv
